/* include/raster_fb_cfg.svh */
// Widths and command encodings shared by the framebuffer clear path.
// Include this file wherever a port width or an opcode is needed.
`ifndef RASTER_FB_CFG_SVH
`define RASTER_FB_CFG_SVH

// Datapath widths
`define CMD_WIDTH        32
`define FB_ADDR_WIDTH    32
`define SCREEN_POS_WIDTH 11

// Opcodes, carried in the top nibble of a header word
`define OP_REG_WRITE 4'h1
`define OP_MEMSET    4'h2
`define OP_SWAP      4'h3

// Register codes that follow an OP_REG_WRITE header
`define REG_FB_ADDR        8'h00
`define REG_RESOLUTION     8'h01
`define REG_SCISSOR_START  8'h02
`define REG_SCISSOR_END    8'h03
`define REG_SCISSOR_ENABLE 8'h04
`define REG_CLEAR_COLOR    8'h05
`define REG_COLOR_MASK     8'h06

`endif

/* hdl/raster_fb_pkg.sv */
// Types for the framebuffer command stream, clear configuration and pixel writes.
// Modules import it in their body and use scoped names in their port lists.
`include "raster_fb_cfg.svh"

package raster_fb_pkg;

    // Zero padding above each coordinate in a half word
    localparam int POS_PAD = `CMD_WIDTH / 2 - `SCREEN_POS_WIDTH;

    typedef struct packed {
        logic [3:0]              opcode;
        logic [7:0]              reg_code;
        logic [`CMD_WIDTH-14:0]  reserved;
        logic                    vsync;
    } cmd_hdr_t;

    // Coordinate payload, Y in the upper half and X in the lower half
    typedef struct packed {
        logic [POS_PAD-1:0]            pad_y;
        logic [`SCREEN_POS_WIDTH-1:0]  y;
        logic [POS_PAD-1:0]            pad_x;
        logic [`SCREEN_POS_WIDTH-1:0]  x;
    } screen_xy_t;

    // One stream word, seen either as a header or as a payload
    typedef union packed {
        cmd_hdr_t               hdr;
        screen_xy_t             xy;
        logic [`CMD_WIDTH-1:0]  raw;
    } cmd_word_u;

    typedef struct packed {
        logic [`FB_ADDR_WIDTH-1:0]     base_addr;
        logic [`SCREEN_POS_WIDTH-1:0]  x_res;
        logic [`SCREEN_POS_WIDTH-1:0]  y_res;
        logic                          scissor_en;
        logic [`SCREEN_POS_WIDTH-1:0]  scissor_start_x;
        logic [`SCREEN_POS_WIDTH-1:0]  scissor_start_y;
        logic [`SCREEN_POS_WIDTH-1:0]  scissor_end_x;   // exclusive
        logic [`SCREEN_POS_WIDTH-1:0]  scissor_end_y;   // exclusive
        logic [31:0]                   clear_color;     // RGBA8888, R in [31:24]
        logic [3:0]                    color_mask;      // {R, G, B, A}
    } fb_clear_cfg_t;

    typedef struct packed {
        logic [`FB_ADDR_WIDTH-1:0]  addr;
        logic [15:0]                data;   // RGB565
        logic [1:0]                 strb;
    } fb_wr_t;

endpackage

/* hdl/fb_cmd_regs.sv */
// Command stream parser and framebuffer register file.
// Starts memset and swap handshakes and stalls the stream until each one closes.
`timescale 1ns/1ns
`include "raster_fb_cfg.svh"

module fb_cmd_regs
(
    input  logic                          aclk,
    input  logic                          rst_n,
    input  logic                          cmd_valid,
    output logic                          cmd_ready,
    input  raster_fb_pkg::cmd_word_u      cmd_data,
    output raster_fb_pkg::fb_clear_cfg_t  cfg,
    output logic                          clear_req,
    input  logic                          clear_ack,
    output logic                          swap_fb,
    output logic                          swap_fb_vsync,
    input  logic                          fb_swapped,
    output logic [`FB_ADDR_WIDTH-1:0]     fb_addr
);
    import raster_fb_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_PAYLOAD, S_CLEAR, S_SWAP} state_t;

    state_t      state;
    logic [7:0]  reg_sel;
    logic        cmd_take;
    screen_xy_t  payload_xy;

    // Stream is open only while no handshake is in flight
    assign cmd_ready  = (state == S_IDLE) || (state == S_PAYLOAD);
    assign cmd_take   = cmd_valid && cmd_ready;
    assign payload_xy = cmd_data.xy;
    assign fb_addr    = cfg.base_addr;

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            state         <= S_IDLE;
            reg_sel       <= '0;
            cfg           <= '0;
            clear_req     <= 1'b0;
            swap_fb       <= 1'b0;
            swap_fb_vsync <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (cmd_take)
                    begin
                        case (cmd_data.hdr.opcode)
                            `OP_REG_WRITE:
                            begin
                                reg_sel <= cmd_data.hdr.reg_code;
                                state   <= S_PAYLOAD;
                            end
                            `OP_MEMSET:
                            begin
                                clear_req <= 1'b1;
                                state     <= S_CLEAR;
                            end
                            `OP_SWAP:
                            begin
                                swap_fb       <= 1'b1;
                                swap_fb_vsync <= cmd_data.hdr.vsync;
                                state         <= S_SWAP;
                            end
                            // unknown opcodes are dropped
                            default: state <= S_IDLE;
                        endcase
                    end
                end
                S_PAYLOAD:
                begin
                    if (cmd_take)
                    begin
                        case (reg_sel)
                            `REG_FB_ADDR: cfg.base_addr <= cmd_data.raw[`FB_ADDR_WIDTH-1:0];
                            `REG_RESOLUTION:
                            begin
                                cfg.x_res <= payload_xy.x;
                                cfg.y_res <= payload_xy.y;
                            end
                            `REG_SCISSOR_START:
                            begin
                                cfg.scissor_start_x <= payload_xy.x;
                                cfg.scissor_start_y <= payload_xy.y;
                            end
                            `REG_SCISSOR_END:
                            begin
                                cfg.scissor_end_x <= payload_xy.x;
                                cfg.scissor_end_y <= payload_xy.y;
                            end
                            `REG_SCISSOR_ENABLE: cfg.scissor_en <= cmd_data.raw[0];
                            `REG_CLEAR_COLOR: cfg.clear_color <= cmd_data.raw;
                            `REG_COLOR_MASK: cfg.color_mask <= cmd_data.raw[3:0];
                            default: ;
                        endcase
                        state <= S_IDLE;
                    end
                end
                S_CLEAR:
                begin
                    // Drop the request on ack, then wait for ack to fall
                    if (clear_req && clear_ack)
                        clear_req <= 1'b0;
                    else if (!clear_req && !clear_ack)
                        state <= S_IDLE;
                end
                S_SWAP:
                begin
                    if (swap_fb && fb_swapped)
                        swap_fb <= 1'b0;
                    else if (!swap_fb && !fb_swapped)
                        state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

/* hdl/fb_clear_engine.sv */
// Memset engine for the RGB565 colour buffer.
// Walks the screen in row-major order and issues one masked write per visible pixel.
`timescale 1ns/1ns
`include "raster_fb_cfg.svh"

module fb_clear_engine
(
    input  logic                          aclk,
    input  logic                          rst_n,
    input  raster_fb_pkg::fb_clear_cfg_t  cfg,
    input  logic                          clear_req,
    output logic                          clear_ack,
    output logic                          mem_wvalid,
    input  logic                          mem_wready,
    output raster_fb_pkg::fb_wr_t         mem_wr
);
    import raster_fb_pkg::*;

    localparam logic [`FB_ADDR_WIDTH-1:0] PIXEL_BYTES = 2;

    typedef enum logic [1:0] {S_IDLE, S_SCAN, S_DRAIN, S_ACK} state_t;

    state_t                        state;
    logic [`SCREEN_POS_WIDTH-1:0]  x_cnt;
    logic [`SCREEN_POS_WIDTH-1:0]  y_cnt;
    logic [`FB_ADDR_WIDTH-1:0]     addr_cnt;
    logic                          stall;
    logic                          in_scissor;
    logic                          row_end;
    logic                          last_pixel;
    logic                          pix_write;
    fb_wr_t                        next_wr;

    assign stall = mem_wvalid && !mem_wready;

    // End coordinates are exclusive
    assign in_scissor = !cfg.scissor_en ||
        ((x_cnt >= cfg.scissor_start_x) && (x_cnt < cfg.scissor_end_x) &&
         (y_cnt >= cfg.scissor_start_y) && (y_cnt < cfg.scissor_end_y));

    assign row_end    = (x_cnt == cfg.x_res - 1'b1);
    assign last_pixel = row_end && (y_cnt == cfg.y_res - 1'b1);

    always_comb
    begin
        next_wr.addr = addr_cnt;
        // Top 5 bits of R, top 6 of G, top 5 of B
        next_wr.data = {cfg.clear_color[31:27], cfg.clear_color[23:18],
                        cfg.clear_color[15:11]};
        // G spans both bytes of the 565 word
        next_wr.strb[0] = cfg.color_mask[1] | cfg.color_mask[2];
        next_wr.strb[1] = cfg.color_mask[3] | cfg.color_mask[2];
    end

    assign pix_write = in_scissor && (|next_wr.strb);

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            state      <= S_IDLE;
            clear_ack  <= 1'b0;
            mem_wvalid <= 1'b0;
            x_cnt      <= '0;
            y_cnt      <= '0;
            addr_cnt   <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (clear_req)
                    begin
                        x_cnt    <= '0;
                        y_cnt    <= '0;
                        addr_cnt <= cfg.base_addr;
                        state    <= S_SCAN;
                    end
                end
                S_SCAN:
                begin
                    // One pixel per cycle unless the pending write is stuck
                    if (!stall)
                    begin
                        mem_wvalid <= pix_write;
                        addr_cnt   <= addr_cnt + PIXEL_BYTES;
                        if (row_end)
                        begin
                            x_cnt <= '0;
                            y_cnt <= y_cnt + 1'b1;
                        end
                        else
                            x_cnt <= x_cnt + 1'b1;
                        if (last_pixel)
                            state <= S_DRAIN;
                    end
                end
                S_DRAIN:
                begin
                    // Last write accepted or none pending
                    if (!stall)
                    begin
                        mem_wvalid <= 1'b0;
                        clear_ack  <= 1'b1;
                        state      <= S_ACK;
                    end
                end
                S_ACK:
                begin
                    if (!clear_req)
                    begin
                        clear_ack <= 1'b0;
                        state     <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if ((state == S_SCAN) && !stall && pix_write)
            mem_wr <= next_wr;
    end

endmodule

/* hdl/raster_fb_top.sv */
// Framebuffer side of the rasterizer: command registers plus the clear engine.
// Exposes the command stream, the display swap handshake and a pixel write port.
`timescale 1ns/1ns
`include "raster_fb_cfg.svh"

module raster_fb_top
(
    input  logic                       aclk,
    input  logic                       rst_n,
    input  logic                       cmd_valid,
    output logic                       cmd_ready,
    input  raster_fb_pkg::cmd_word_u   cmd_data,
    output logic                       swap_fb,
    output logic                       swap_fb_vsync,
    input  logic                       fb_swapped,
    output logic [`FB_ADDR_WIDTH-1:0]  fb_addr,
    output logic                       mem_wvalid,
    input  logic                       mem_wready,
    output raster_fb_pkg::fb_wr_t      mem_wr
);
    import raster_fb_pkg::*;

    fb_clear_cfg_t  cfg;
    logic           clear_req;
    logic           clear_ack;

    fb_cmd_regs i_cmd_regs
    (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .cmd_data      (cmd_data),
        .cfg           (cfg),
        .clear_req     (clear_req),
        .clear_ack     (clear_ack),
        .swap_fb       (swap_fb),
        .swap_fb_vsync (swap_fb_vsync),
        .fb_swapped    (fb_swapped),
        .fb_addr       (fb_addr)
    );

    fb_clear_engine i_clear_engine
    (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .clear_req  (clear_req),
        .clear_ack  (clear_ack),
        .mem_wvalid (mem_wvalid),
        .mem_wready (mem_wready),
        .mem_wr     (mem_wr)
    );

endmodule

/* bench/raster_fb_sva.sv */
// Protocol assertions for the framebuffer top level.
// Attached to every raster_fb_top instance by the bind at the end of this file.
`timescale 1ns/1ns

module raster_fb_sva
(
    input logic                   aclk,
    input logic                   rst_n,
    input logic                   mem_wvalid,
    input logic                   mem_wready,
    input raster_fb_pkg::fb_wr_t  mem_wr,
    input logic                   swap_fb,
    input logic                   fb_swapped
);

    // A stalled write keeps its valid and its payload
    property wr_held_p;
        @(posedge aclk) disable iff (!rst_n)
        (mem_wvalid && !mem_wready) |=> (mem_wvalid && $stable(mem_wr));
    endproperty

    // swap_fb may only fall once the display has answered
    property swap_held_p;
        @(posedge aclk) disable iff (!rst_n)
        (swap_fb && !fb_swapped) |=> swap_fb;
    endproperty

    property no_write_in_reset_p;
        @(posedge aclk)
        (!rst_n && $past(!rst_n)) |-> !mem_wvalid;
    endproperty

    assert property (wr_held_p)
        else $error("Write changed or vanished while stalled");
    assert property (swap_held_p)
        else $error("swap_fb fell before fb_swapped");
    assert property (no_write_in_reset_p)
        else $error("mem_wvalid high during reset");

endmodule

bind raster_fb_top raster_fb_sva i_sva
(
    .aclk       (aclk),
    .rst_n      (rst_n),
    .mem_wvalid (mem_wvalid),
    .mem_wready (mem_wready),
    .mem_wr     (mem_wr),
    .swap_fb    (swap_fb),
    .fb_swapped (fb_swapped)
);

/* bench/tb_raster_fb.sv */
// Drives the framebuffer clear path over its command stream and checks each pixel write
// against a model, while a display model answers the swap handshake.
`timescale 1ns/1ns
`include "raster_fb_cfg.svh"

module tb_raster_fb;
    import raster_fb_pkg::*;

    localparam int NUM_TESTS    = 6;
    localparam int MAX_WORDS    = 12;
    localparam int RESET_CYCLES = 8;
    localparam int SCREEN_W     = 8;
    localparam int SCREEN_H     = 4;
    localparam int TEST_MARGIN  = 100;
    localparam int PAD          = `CMD_WIDTH / 2 - `SCREEN_POS_WIDTH;

    logic                       aclk = 1'b0;
    logic                       rst_n;
    logic                       cmd_valid;
    logic                       cmd_ready;
    cmd_word_u                  cmd_data;
    logic                       swap_fb;
    logic                       swap_fb_vsync;
    logic                       fb_swapped;
    logic [`FB_ADDR_WIDTH-1:0]  fb_addr;
    logic                       mem_wvalid;
    logic                       mem_wready;
    fb_wr_t                     mem_wr;

    // One table entry per test
    string        tbl_name [NUM_TESTS];
    int           tbl_len [NUM_TESTS];
    logic [31:0]  tbl_cmd [NUM_TESTS][MAX_WORDS];
    bit           tbl_rand [NUM_TESTS];
    int           tbl_writes [NUM_TESTS];

    // Register state as the model sees it from the sent commands
    logic [31:0]  m_base;
    int           m_xres;
    int           m_yres;
    bit           m_sc_en;
    int           m_sx0;
    int           m_sy0;
    int           m_sx1;
    int           m_sy1;
    logic [31:0]  m_color;
    logic [3:0]   m_mask;

    fb_wr_t       exp_q [$];
    fb_wr_t       exp_wr;
    string        cur_name;
    int           wr_count = 0;
    bit           rand_ready = 1'b0;
    logic [31:0]  rand_state = 32'd51607;

    raster_fb_top i_dut
    (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .cmd_data      (cmd_data),
        .swap_fb       (swap_fb),
        .swap_fb_vsync (swap_fb_vsync),
        .fb_swapped    (fb_swapped),
        .fb_addr       (fb_addr),
        .mem_wvalid    (mem_wvalid),
        .mem_wready    (mem_wready),
        .mem_wr        (mem_wr)
    );

    always #50 aclk = ~aclk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] make_header(input logic [3:0] op, input logic [7:0] code,
                                                input logic vsync);
        return {op, code, 19'd0, vsync};
    endfunction

    function automatic logic [31:0] make_xy(input logic [`SCREEN_POS_WIDTH-1:0] x,
                                            input logic [`SCREEN_POS_WIDTH-1:0] y);
        return {{PAD{1'b0}}, y, {PAD{1'b0}}, x};
    endfunction

    // RGB565 keeps the top bits of each channel, so divide down and pack
    function automatic logic [15:0] rgb565_of(input logic [31:0] rgba);
        int r5;
        int g6;
        int b5;
        r5 = int'(rgba[31:24]) / 8;
        g6 = int'(rgba[23:16]) / 4;
        b5 = int'(rgba[15:8]) / 8;
        return 16'(r5 * 2048 + g6 * 32 + b5);
    endfunction

    // A byte is written when any of its bits belongs to an enabled channel
    function automatic logic [1:0] strobe_of(input logic [3:0] mask);
        logic [15:0] bit_en;
        bit_en = {{5{mask[3]}}, {6{mask[2]}}, {5{mask[1]}}};
        return {|bit_en[15:8], |bit_en[7:0]};
    endfunction

    task report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task check(input string name, input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual)
            report_failure($sformatf("ERROR: %s expected %0h actual %0h",
                                     name, expected, actual));
    endtask

    task add_word(input int t, input logic [31:0] w);
        tbl_cmd[t][tbl_len[t]] = w;
        tbl_len[t]++;
    endtask

    task add_reg(input int t, input logic [7:0] code, input logic [31:0] value);
        add_word(t, make_header(`OP_REG_WRITE, code, 1'b0));
        add_word(t, value);
    endtask

    task start_entry(input int t, input string name, input bit rnd, input int writes);
        tbl_name[t]   = name;
        tbl_len[t]    = 0;
        tbl_rand[t]   = rnd;
        tbl_writes[t] = writes;
    endtask

    task load_table;
        start_entry(0, "full_screen", 1'b0, 32);
        add_reg(0, `REG_FB_ADDR, 32'h0001_0000);
        add_reg(0, `REG_RESOLUTION, make_xy(11'd8, 11'd4));
        add_reg(0, `REG_SCISSOR_ENABLE, 32'd0);
        add_reg(0, `REG_CLEAR_COLOR, 32'hC65A_F080);
        add_reg(0, `REG_COLOR_MASK, 32'hF);
        add_word(0, make_header(`OP_MEMSET, 8'h00, 1'b0));
        // Rectangle (2,1) to (5,3) with exclusive end
        start_entry(1, "scissor", 1'b0, 6);
        add_reg(1, `REG_SCISSOR_START, make_xy(11'd2, 11'd1));
        add_reg(1, `REG_SCISSOR_END, make_xy(11'd5, 11'd3));
        add_reg(1, `REG_SCISSOR_ENABLE, 32'd1);
        add_word(1, make_header(`OP_MEMSET, 8'h00, 1'b0));
        start_entry(2, "mask_r", 1'b0, 32);
        add_reg(2, `REG_SCISSOR_ENABLE, 32'd0);
        add_reg(2, `REG_COLOR_MASK, 32'h8);
        add_word(2, make_header(`OP_MEMSET, 8'h00, 1'b0));
        // Alpha has no byte in RGB565
        start_entry(3, "mask_a", 1'b0, 0);
        add_reg(3, `REG_COLOR_MASK, 32'h1);
        add_word(3, make_header(`OP_MEMSET, 8'h00, 1'b0));
        start_entry(4, "random_ready", 1'b1, 32);
        add_reg(4, `REG_COLOR_MASK, 32'hF);
        add_word(4, make_header(`OP_MEMSET, 8'h00, 1'b0));
        start_entry(5, "swap_vsync", 1'b0, 0);
        add_reg(5, `REG_FB_ADDR, 32'h0002_4000);
        add_word(5, make_header(`OP_SWAP, 8'h00, 1'b1));
    endtask

    task update_model(input logic [7:0] code, input logic [31:0] w);
        case (code)
            `REG_FB_ADDR: m_base = w;
            `REG_RESOLUTION:
            begin
                m_xres = int'(w[`SCREEN_POS_WIDTH-1:0]);
                m_yres = int'(w[16 +: `SCREEN_POS_WIDTH]);
            end
            `REG_SCISSOR_START:
            begin
                m_sx0 = int'(w[`SCREEN_POS_WIDTH-1:0]);
                m_sy0 = int'(w[16 +: `SCREEN_POS_WIDTH]);
            end
            `REG_SCISSOR_END:
            begin
                m_sx1 = int'(w[`SCREEN_POS_WIDTH-1:0]);
                m_sy1 = int'(w[16 +: `SCREEN_POS_WIDTH]);
            end
            `REG_SCISSOR_ENABLE: m_sc_en = w[0];
            `REG_CLEAR_COLOR: m_color = w;
            `REG_COLOR_MASK: m_mask = w[3:0];
            default: ;
        endcase
    endtask

    // Expected writes in row-major order at base + 2 * (y * xres + x)
    task automatic build_expected;
        fb_wr_t  wr;
        bit      inside_sc;
        exp_q.delete();
        wr.data = rgb565_of(m_color);
        wr.strb = strobe_of(m_mask);
        for (int y = 0; y < m_yres; y++)
        begin
            for (int x = 0; x < m_xres; x++)
            begin
                inside_sc = !m_sc_en ||
                    ((x >= m_sx0) && (x < m_sx1) && (y >= m_sy0) && (y < m_sy1));
                if (inside_sc && (wr.strb != 2'b00))
                begin
                    wr.addr = m_base + 32'(2 * (y * m_xres + x));
                    exp_q.push_back(wr);
                end
            end
        end
    endtask

    // Returns at the falling edge after the word was taken
    task send_word(input logic [31:0] w);
        @(posedge aclk);
        cmd_valid <= 1'b1;
        cmd_data  <= w;
        @(negedge aclk);
        while (!cmd_ready)
            @(negedge aclk);
        @(posedge aclk);
        cmd_valid <= 1'b0;
        @(negedge aclk);
    endtask

    task automatic run_memset(input int t, input logic [31:0] w);
        build_expected();
        wr_count = 0;
        send_word(w);
        check({cur_name, " cmd_ready after header"}, 32'd0, 32'(cmd_ready));
        while (!cmd_ready)
            @(negedge aclk);
        check({cur_name, " write count"}, tbl_writes[t], wr_count);
        check({cur_name, " writes left over"}, 32'd0, exp_q.size());
    endtask

    task automatic run_swap(input logic [31:0] w);
        bit seen_swapped;
        seen_swapped = 1'b0;
        send_word(w);
        check({cur_name, " swap_fb"}, 32'd1, 32'(swap_fb));
        check({cur_name, " swap_fb_vsync"}, 32'(w[0]), 32'(swap_fb_vsync));
        check({cur_name, " fb_addr"}, m_base, fb_addr);
        // Stream stays closed until the display has dropped fb_swapped
        while (!cmd_ready)
        begin
            if (fb_swapped)
                seen_swapped = 1'b1;
            @(negedge aclk);
        end
        check({cur_name, " fb_swapped seen"}, 32'd1, 32'(seen_swapped));
        check({cur_name, " fb_swapped at ready"}, 32'd0, 32'(fb_swapped));
        check({cur_name, " swap_fb at ready"}, 32'd0, 32'(swap_fb));
    endtask

    task automatic run_test(input int t);
        logic [31:0]  w;
        logic [7:0]   pending_reg;
        bit           payload_next;
        cur_name     = tbl_name[t];
        rand_ready   = tbl_rand[t];
        payload_next = 1'b0;
        pending_reg  = 8'h00;
        for (int i = 0; i < tbl_len[t]; i++)
        begin
            w = tbl_cmd[t][i];
            if (payload_next)
            begin
                update_model(pending_reg, w);
                send_word(w);
                payload_next = 1'b0;
            end
            else if (w[31:28] == `OP_REG_WRITE)
            begin
                pending_reg  = w[27:20];
                payload_next = 1'b1;
                send_word(w);
            end
            else if (w[31:28] == `OP_MEMSET)
                run_memset(t, w);
            else if (w[31:28] == `OP_SWAP)
                run_swap(w);
            else
                report_failure("Test table holds a word with an unknown opcode");
        end
        rand_ready = 1'b0;
    endtask

    // Memory ready is either held high or drawn from the LCG
    initial
    begin
        mem_wready <= 1'b0;
        forever
        begin
            @(posedge aclk);
            rand_state = lcg_next(rand_state);
            if (rand_ready)
                mem_wready <= rand_state[16];
            else
                mem_wready <= 1'b1;
        end
    end

    // Display answers a swap after a short random delay
    initial
    begin : display_model
        int delay;
        fb_swapped <= 1'b0;
        forever
        begin
            @(negedge aclk);
            if (swap_fb && !fb_swapped)
            begin
                delay = int'(rand_state[9:8]) + 1;
                repeat (delay) @(posedge aclk);
                fb_swapped <= 1'b1;
                @(negedge aclk);
                while (swap_fb)
                    @(negedge aclk);
                @(posedge aclk);
                fb_swapped <= 1'b0;
            end
        end
    end

    // Inputs only change on rising edges, so the falling edge sees a settled handshake
    always @(negedge aclk)
    begin
        if (rst_n && mem_wvalid && mem_wready)
        begin
            if (exp_q.size() == 0)
                report_failure($sformatf("%s issued a write to %0h when none was expected",
                                         cur_name, mem_wr.addr));
            else
            begin
                exp_wr = exp_q.pop_front();
                check({cur_name, " write addr"}, exp_wr.addr, mem_wr.addr);
                check({cur_name, " write data"}, 32'(exp_wr.data), 32'(mem_wr.data));
                check({cur_name, " write strb"}, 32'(exp_wr.strb), 32'(mem_wr.strb));
                wr_count++;
            end
        end
    end

    initial
    begin : watchdog
        int limit;
        limit = RESET_CYCLES + NUM_TESTS * (SCREEN_W * SCREEN_H * 4 + TEST_MARGIN);
        repeat (limit) @(posedge aclk);
        report_failure("Watchdog expired before all tests finished");
    end

    initial
    begin
        rst_n     <= 1'b0;
        cmd_valid <= 1'b0;
        cmd_data  <= '0;
        load_table();
        repeat (RESET_CYCLES) @(posedge aclk);
        rst_n <= 1'b1;
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);
        $display("TEST PASS");
        $finish;
    end

endmodule

/* compile.f */
+incdir+include
hdl/raster_fb_pkg.sv
hdl/fb_cmd_regs.sv
hdl/fb_clear_engine.sv
hdl/raster_fb_top.sv
bench/raster_fb_sva.sv
bench/tb_raster_fb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_raster_fb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
